//--- issueUnit.f
common/issuePkg.sv
regIdDecode/regIdDecode.sv
rtl/instrQueue.sv
rtl/hazardScoreboard.sv
rtl/issueCtrl.sv
rtl/issueUnit.sv
verif/issueUnitTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the issue unit testbench with Verilator, then scan the log

verilator --binary --timing --assert -Wno-fatal -f issueUnit.f \
  --top-module issueUnitTb -o simIssueUnit > build.log 2>&1 ||
  { cat build.log; echo "Build error"; exit 1; }

./obj_dir/simIssueUnit > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

//--- verif/issueUnitTb.sv
`timescale 1ns/10ps

module issueUnitTb;

  localparam int ACK_LIMIT = 60;
  localparam int WAIT_LIMIT = 400;

  logic             clk;
  logic             rstN;
  logic             cyc;
  logic             stb;
  logic             we;
  issuePkg::wbAddrT adr;
  issuePkg::instrT  datIn;
  logic             ack;
  issuePkg::instrT  datOut;
  logic             issueValid;
  issuePkg::instrT  issueInstr;
  issuePkg::regIdT  issueWrReg;
  logic             issueWrValid;
  logic             issueReady;

  // Reference model state
  issuePkg::instrT modelQ[$];
  logic            modelHalted;
  int              lastWr[8];  // Cycle of the last transfer writing each register
  int              cycleNow;
  int              stallExp;
  int              transfers;
  int              errors;
  int              readyMode;  // 0 always ready, 1 random, 2 held low
  string           testName;

  issueUnit u_issueUnit (
    .clk          (clk),
    .rstN         (rstN),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .datIn        (datIn),
    .ack          (ack),
    .datOut       (datOut),
    .issueValid   (issueValid),
    .issueInstr   (issueInstr),
    .issueWrReg   (issueWrReg),
    .issueWrValid (issueWrValid),
    .issueReady   (issueReady)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    issueReady <= #1 (readyMode == 0) || ((readyMode == 1) && ($urandom_range(3) != 0));
  end

  // Register use per opcode class as {aValid, a, bValid, b, wrValid, wr}
  function automatic logic [11:0] refDecode(input issuePkg::instrT w);
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    logic [2:0] lk;
    rs = w[10:8];
    rt = w[7:5];
    rd = w[4:2];
    lk = issuePkg::LINK_REG;
    case (w[15:11]) inside
      [5'b01000:5'b01011], [5'b10100:5'b10111]: return {1'b1, rs, 4'b0, 1'b1, rt};
      [5'b11010:5'b11111]: return {1'b1, rs, 1'b1, rt, 1'b1, rd};
      5'b11001: return {1'b1, rs, 4'b0, 1'b1, rd};
      [5'b01100:5'b01111], 5'b00101: return {1'b1, rs, 8'b0};
      5'b11000: return {8'b0, 1'b1, rs};
      5'b10010: return {1'b1, rs, 4'b0, 1'b1, rs};
      5'b10000: return {1'b1, rs, 1'b1, rt, 4'b0};
      5'b10001: return {1'b1, rs, 4'b0, 1'b1, rt};
      5'b10011: return {1'b1, rs, 1'b1, rt, 1'b1, rs};
      5'b00110: return {4'b0, 1'b1, lk, 1'b1, lk};
      5'b00111: return {1'b1, rs, 1'b1, lk, 1'b1, lk};
      default: return 12'b0;
    endcase
  endfunction

  // A source written less than four cycles ago blocks issue
  function automatic logic headBlocked(input issuePkg::instrT w);
    logic [11:0] d;
    d = refDecode(w);
    return (d[11] && (cycleNow - lastWr[d[10:8]] < 4)) ||
           (d[7] && (cycleNow - lastWr[d[6:4]] < 4));
  endfunction

  // Registers limited to R0..R3 so hazards are frequent
  function automatic issuePkg::instrT randInstr();
    issuePkg::instrT w;
    w = issuePkg::instrT'($urandom);
    if (w[15:11] == issuePkg::OP_HALT)
    begin
      w[15:11] = 5'b00001;  // Turn into NOP
    end
    w[10] = 1'b0;
    w[7]  = 1'b0;
    w[4]  = 1'b0;
    return w;
  endfunction

  task automatic reportMismatch(input string what, input int expVal, input int actVal);
    errors++;
    $display("** Error [%s] %s: expected %0h, actual %0h", testName, what, expVal, actVal);
  endtask

  task automatic noteFailure(input string msg);
    errors++;
    $display("Failure in %s: %s", testName, msg);
  endtask

  task automatic finishRun();
    $display("Run complete with %0d errors over %0d transfers", errors, transfers);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic wbXfer(input logic write, input issuePkg::wbAddrT a, input issuePkg::instrT d);
    int n;
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    datIn = d;
    n     = 0;
    while (!ack && n < ACK_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!ack)
    begin
      noteFailure("host transfer got no ack");
      finishRun();
    end
    else
    begin
      @(posedge clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
    end
  endtask

  task automatic waitModel(input logic forHalt);
    int n;
    n = 0;
    while ((forHalt ? !modelHalted : (modelQ.size() != 0)) && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (forHalt ? !modelHalted : (modelQ.size() != 0))
    begin
      noteFailure(forHalt ? "HALT never transferred" : "queue never drained");
      finishRun();
    end
  endtask

  // Presented instruction holds while downstream is not ready
  stableWhileBlocked: assert property (@(posedge clk) disable iff (!rstN)
    (issueValid && !issueReady) |=> (issueValid && $stable(issueInstr) &&
                                     $stable(issueWrReg) && $stable(issueWrValid)))
    else noteFailure("issue outputs changed while ready was low");

  always @(negedge clk)
  begin : refModel
    logic [11:0]     dec;
    logic            blocked;
    logic            expValid;
    int              qSize;
    issuePkg::instrT head;
    if (rstN)
    begin
      cycleNow++;
      qSize   = modelQ.size();
      blocked = 1'b0;
      if (qSize > 0)
      begin
        blocked = headBlocked(modelQ[0]);
      end
      expValid = (qSize > 0) && !modelHalted && !blocked;
      assert (issueValid == expValid)
        else reportMismatch("issueValid", expValid, issueValid);
      if (expValid)
      begin
        dec = refDecode(modelQ[0]);
        assert (issueInstr == modelQ[0])
          else reportMismatch("issueInstr", modelQ[0], issueInstr);
        assert ({issueWrValid, issueWrReg} == dec[3:0])
          else reportMismatch("issueWr", dec[3:0], {issueWrValid, issueWrReg});
      end
      if (ack && cyc && stb && !we && adr == issuePkg::ADDR_STATUS)
      begin
        assert (int'(datOut[2:0]) == qSize)
          else reportMismatch("status count", qSize, datOut[2:0]);
        assert (datOut[3] == modelHalted)
          else reportMismatch("status halted", modelHalted, datOut[3]);
        assert (int'(datOut[15:8]) == stallExp)
          else reportMismatch("status stalls", stallExp, datOut[15:8]);
      end
      if (qSize > 0 && !modelHalted && issueReady && blocked && stallExp < 255)
      begin
        stallExp++;
      end
      if (expValid && issueReady)
      begin
        head = modelQ.pop_front();
        dec  = refDecode(head);
        if (dec[3])
        begin
          lastWr[dec[2:0]] = cycleNow;
        end
        if (head[15:11] == issuePkg::OP_HALT)
        begin
          modelHalted = 1'b1;
        end
        transfers++;
      end
      if (ack && cyc && stb && we && adr == issuePkg::ADDR_INSTR)
      begin
        assert (qSize < issuePkg::QUEUE_DEPTH)
          else noteFailure("push acked while the queue was full");
        modelQ.push_back(datIn);
      end
      if (ack && cyc && stb && we && adr == issuePkg::ADDR_RESUME && datIn[0])
      begin
        modelHalted = 1'b0;
      end
    end
  end

  initial
  begin
    void'($urandom(98));
    clk         = 1'b0;
    rstN        = 1'b0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    datIn       = '0;
    issueReady  = 1'b1;
    readyMode   = 0;
    modelHalted = 1'b0;
    cycleNow    = 0;
    stallExp    = 0;
    transfers   = 0;
    errors      = 0;
    testName    = "reset";
    foreach (lastWr[r])
    begin
      lastWr[r] = -100;
    end
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    testName = "random mix";
    @(negedge clk);
    readyMode = 1;
    for (int i = 0; i < 40; i++)
    begin
      wbXfer(1'b1, issuePkg::ADDR_INSTR, randInstr());
      if (i % 8 == 7)
      begin
        wbXfer(1'b0, issuePkg::ADDR_STATUS, '0);
      end
    end
    waitModel(1'b0);

    testName = "back-pressure";
    @(negedge clk);
    readyMode = 2;
    for (int i = 0; i < issuePkg::QUEUE_DEPTH; i++)
    begin
      wbXfer(1'b1, issuePkg::ADDR_INSTR, randInstr());
    end
    wbXfer(1'b0, issuePkg::ADDR_STATUS, '0);
    fork
      wbXfer(1'b1, issuePkg::ADDR_INSTR, randInstr());  // Held until an entry frees
      begin
        repeat (6) @(negedge clk);
        readyMode = 0;
      end
    join
    waitModel(1'b0);

    testName = "halt";
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'hC100);
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h0000);  // HALT
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h4140);
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'hD94C);
    waitModel(1'b1);
    repeat (5) @(posedge clk);
    wbXfer(1'b0, issuePkg::ADDR_STATUS, '0);
    wbXfer(1'b1, issuePkg::ADDR_RESUME, 16'h0001);
    waitModel(1'b0);

    testName = "hazard chain";
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'hC100);  // LBI R1
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h4140);  // ADDI R2 from R1
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'hD94C);  // ADD R3 from R1 R2
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h8320);  // ST reads R3 R1
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h3000);  // JAL
    wbXfer(1'b1, issuePkg::ADDR_INSTR, 16'h3F00);  // JALR back to back on R7
    waitModel(1'b0);
    wbXfer(1'b0, issuePkg::ADDR_STATUS, '0);
    finishRun();
  end

endmodule

//--- rtl/issueUnit.sv
`timescale 1ns/10ps

module issueUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  issuePkg::wbAddrT adr,
  input  issuePkg::instrT  datIn,
  output logic             ack,
  output issuePkg::instrT  datOut,
  output logic             issueValid,
  output issuePkg::instrT  issueInstr,
  output issuePkg::regIdT  issueWrReg,
  output logic             issueWrValid,
  input  logic             issueReady
);

  issuePkg::queueCountT count;
  issuePkg::regIdT      srcA;
  issuePkg::regIdT      srcB;
  logic                 srcAValid;
  logic                 srcBValid;
  logic                 empty;
  logic                 full;
  logic                 push;
  logic                 pop;
  logic                 hazard;

  instrQueue u_instrQueue (
    .clk      (clk),
    .rstN     (rstN),
    .push     (push),
    .pushData (datIn),
    .pop      (pop),
    .headData (issueInstr),  // Head is presented downstream
    .empty    (empty),
    .full     (full),
    .count    (count)
  );

  regIdDecode u_regIdDecode (
    .instr     (issueInstr),
    .srcA      (srcA),
    .srcAValid (srcAValid),
    .srcB      (srcB),
    .srcBValid (srcBValid),
    .wrReg     (issueWrReg),
    .wrValid   (issueWrValid)
  );

  hazardScoreboard u_hazardScoreboard (
    .clk        (clk),
    .rstN       (rstN),
    .enter      (pop),  // Transfer records the destination
    .enterReg   (issueWrReg),
    .enterValid (issueWrValid),
    .srcA       (srcA),
    .srcAValid  (srcAValid),
    .srcB       (srcB),
    .srcBValid  (srcBValid),
    .hazard     (hazard)
  );

  issueCtrl u_issueCtrl (
    .clk        (clk),
    .rstN       (rstN),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .datIn      (datIn),
    .ack        (ack),
    .datOut     (datOut),
    .empty      (empty),
    .full       (full),
    .count      (count),
    .headOpcode (issueInstr[issuePkg::OPC_MSB:issuePkg::OPC_LSB]),
    .hazard     (hazard),
    .issueReady (issueReady),
    .issueValid (issueValid),
    .push       (push),
    .pop        (pop)
  );

endmodule

//--- rtl/issueCtrl.sv
`timescale 1ns/10ps

module issueCtrl (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  issuePkg::wbAddrT     adr,
  input  issuePkg::instrT      datIn,
  output logic                 ack,
  output issuePkg::instrT      datOut,
  input  logic                 empty,
  input  logic                 full,
  input  issuePkg::queueCountT count,
  input  issuePkg::opcodeT     headOpcode,
  input  logic                 hazard,
  input  logic                 issueReady,
  output logic                 issueValid,
  output logic                 push,
  output logic                 pop
);

  issuePkg::issueStateT state;
  issuePkg::issueStateT stateNext;
  issuePkg::stallCountT stallCount;
  logic                 wbReq;
  logic                 instrWrite;
  logic                 resumeWrite;
  logic                 stallCycle;

  assign wbReq      = cyc & stb & ~ack;  // New request, not the ack cycle
  assign instrWrite = we & (adr == issuePkg::ADDR_INSTR);

  // Push to a full queue waits here without ack
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      ack <= 1'b0;
    end
    else
    begin
      ack <= wbReq & ~(instrWrite & full);
    end
  end

  assign push        = ack & cyc & stb & instrWrite;
  assign resumeWrite = ack & cyc & stb & we & (adr == issuePkg::ADDR_RESUME) &
                       datIn[issuePkg::RESUME_BIT];

  always_comb
  begin
    datOut = '0;
    if (adr == issuePkg::ADDR_STATUS)
    begin
      datOut[issuePkg::STAT_COUNT_LSB +: $bits(count)]      = count;
      datOut[issuePkg::STAT_HALT_BIT]                       = (state == issuePkg::HALTED);
      datOut[issuePkg::STAT_STALL_LSB +: $bits(stallCount)] = stallCount;
    end
  end

  // Issue decision
  assign issueValid = ~empty & (state == issuePkg::RUN) & ~hazard;
  assign pop        = issueValid & issueReady;  // Transfer
  assign stallCycle = ~empty & (state == issuePkg::RUN) & issueReady & hazard;

  always_comb
  begin
    stateNext = state;
    case (state)
      issuePkg::RUN:
      begin
        if (pop && (headOpcode == issuePkg::OP_HALT))
        begin
          stateNext = issuePkg::HALTED;
        end
      end
      issuePkg::HALTED:
      begin
        if (resumeWrite)
        begin
          stateNext = issuePkg::RUN;
        end
      end
      default: stateNext = issuePkg::RUN;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state      <= issuePkg::RUN;
      stallCount <= '0;
    end
    else
    begin
      state <= stateNext;
      if (stallCycle && (stallCount != issuePkg::STALL_MAX))
      begin
        stallCount <= stallCount + 1'b1;  // Sticks at max
      end
    end
  end

endmodule

//--- rtl/hazardScoreboard.sv
`timescale 1ns/10ps

module hazardScoreboard (
  input  logic            clk,
  input  logic            rstN,
  input  logic            enter,
  input  issuePkg::regIdT enterReg,
  input  logic            enterValid,
  input  issuePkg::regIdT srcA,
  input  logic            srcAValid,
  input  issuePkg::regIdT srcB,
  input  logic            srcBValid,
  output logic            hazard
);

  // Slot 0 is EX, slot SB_DEPTH-1 is WB
  issuePkg::regIdT                slotReg [issuePkg::SB_DEPTH];
  logic [issuePkg::SB_DEPTH-1:0]  slotValid;

  always_ff @(posedge clk)
  begin
    slotReg[0] <= enterReg;
    for (int i = 1; i < issuePkg::SB_DEPTH; i++)
    begin
      slotReg[i] <= slotReg[i-1];
    end
  end

  // A bubble enters whenever nothing is issued
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      slotValid <= '0;
    end
    else
    begin
      slotValid <= {slotValid[issuePkg::SB_DEPTH-2:0], enter & enterValid};
    end
  end

  // RAW check of both head sources against every in-flight writer
  always_comb
  begin
    hazard = 1'b0;
    for (int i = 0; i < issuePkg::SB_DEPTH; i++)
    begin
      if (slotValid[i])
      begin
        if (srcAValid && (srcA == slotReg[i]))
        begin
          hazard = 1'b1;
        end
        if (srcBValid && (srcB == slotReg[i]))
        begin
          hazard = 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/instrQueue.sv
`timescale 1ns/10ps

module instrQueue (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 push,
  input  issuePkg::instrT      pushData,
  input  logic                 pop,
  output issuePkg::instrT      headData,
  output logic                 empty,
  output logic                 full,
  output issuePkg::queueCountT count
);

  issuePkg::instrT    mem [issuePkg::QUEUE_DEPTH];
  issuePkg::queuePtrT wrPtr;
  issuePkg::queuePtrT rdPtr;
  logic               doPush;
  logic               doPop;

  assign empty = (count == '0);
  assign full  = (count == issuePkg::queueCountT'(issuePkg::QUEUE_DEPTH));

  assign doPush = push & ~full;  // Overflow guard
  assign doPop  = pop & ~empty;

  assign headData = mem[rdPtr];

  // Storage
  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

//--- regIdDecode/regIdDecode.sv
`timescale 1ns/10ps

module regIdDecode (
  input  issuePkg::instrT instr,
  output issuePkg::regIdT srcA,
  output logic            srcAValid,
  output issuePkg::regIdT srcB,
  output logic            srcBValid,
  output issuePkg::regIdT wrReg,
  output logic            wrValid
);

  issuePkg::opcodeT opcode;
  issuePkg::regIdT  rsField;
  issuePkg::regIdT  rtField;
  issuePkg::regIdT  rdField;

  assign opcode  = instr[issuePkg::OPC_MSB:issuePkg::OPC_LSB];
  assign rsField = instr[10:8];
  assign rtField = instr[7:5];
  assign rdField = instr[4:2];

  always_comb
  begin
    // Nothing read or written unless a class says so
    srcA      = '0;
    srcAValid = 1'b0;
    srcB      = '0;
    srcBValid = 1'b0;
    wrReg     = '0;
    wrValid   = 1'b0;
    casez (opcode)
      5'b000??:  // HALT NOP SIIC RTI
      begin
      end
      5'b010??:  // ADDI SUBI XORI ANDNI
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        wrReg     = rtField;  // Immediate format writes bits 7:5
        wrValid   = 1'b1;
      end
      5'b101??:  // ROLI SLLI RORI SRLI
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        wrReg     = rtField;
        wrValid   = 1'b1;
      end
      5'b1101?,  // ADD SUB XOR ANDN ROL SLL ROR SRL
      5'b111??:  // SEQ SLT SLE SCO
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        srcB      = rtField;
        srcBValid = 1'b1;
        wrReg     = rdField;
        wrValid   = 1'b1;
      end
      5'b11001:  // BTR
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        wrReg     = rdField;
        wrValid   = 1'b1;
      end
      5'b011??,  // BEQZ BNEZ BLTZ BGEZ
      5'b00101:  // JR
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
      end
      5'b11000:  // LBI
      begin
        wrReg   = rsField;
        wrValid = 1'b1;
      end
      5'b10010:  // SLBI reads and writes the same register
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        wrReg     = rsField;
        wrValid   = 1'b1;
      end
      5'b10000:  // ST
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        srcB      = rtField;
        srcBValid = 1'b1;
      end
      5'b10001:  // LD
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        wrReg     = rtField;
        wrValid   = 1'b1;
      end
      5'b10011:  // STU updates the base register
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        srcB      = rtField;
        srcBValid = 1'b1;
        wrReg     = rsField;
        wrValid   = 1'b1;
      end
      5'b00100:  // J
      begin
      end
      5'b00110:  // JAL
      begin
        srcB      = issuePkg::LINK_REG;
        srcBValid = 1'b1;
        wrReg     = issuePkg::LINK_REG;
        wrValid   = 1'b1;
      end
      5'b00111:  // JALR
      begin
        srcA      = rsField;
        srcAValid = 1'b1;
        srcB      = issuePkg::LINK_REG;
        srcBValid = 1'b1;
        wrReg     = issuePkg::LINK_REG;
        wrValid   = 1'b1;
      end
      default:
      begin
        // Unknown opcode touches no register
      end
    endcase
  end

endmodule

//--- common/issuePkg.sv
package issuePkg;

  // Instruction word layout
  localparam int INSTR_W = 16;
  localparam int OPC_MSB = 15;
  localparam int OPC_LSB = 11;
  localparam int REG_W = 3;

  typedef logic [INSTR_W-1:0] instrT;
  typedef logic [OPC_MSB-OPC_LSB:0] opcodeT;
  typedef logic [REG_W-1:0] regIdT;

  // Host bus word addresses
  typedef logic [1:0] wbAddrT;

  localparam wbAddrT ADDR_INSTR = 2'd0;   // Write pushes an instruction
  localparam wbAddrT ADDR_STATUS = 2'd1;  // Read returns status
  localparam wbAddrT ADDR_RESUME = 2'd2;  // Write with go bit leaves HALTED

  // Go bit in the resume command word
  localparam int RESUME_BIT = 0;

  // Instruction queue
  localparam int QUEUE_DEPTH = 4;

  typedef logic [$clog2(QUEUE_DEPTH):0] queueCountT;
  typedef logic [$clog2(QUEUE_DEPTH)-1:0] queuePtrT;

  // In-flight stages behind issue (EX, MEM, WB)
  localparam int SB_DEPTH = 3;

  // Special opcodes and registers
  localparam opcodeT OP_HALT = 5'b00000;
  localparam regIdT LINK_REG = 3'd7;  // R7 holds the return address

  // Stall counter saturates instead of wrapping
  typedef logic [7:0] stallCountT;

  localparam stallCountT STALL_MAX = '1;

  // Status word fields
  localparam int STAT_COUNT_LSB = 0;
  localparam int STAT_HALT_BIT = 3;
  localparam int STAT_STALL_LSB = 8;

  // Issue control states
  typedef enum logic
  {
    RUN,
    HALTED
  } issueStateT;

endpackage
